// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // cycles of bus wait before the watchdog gives up
  localparam int LSU_TIMEOUT   = 64;
  localparam int LSU_TIMEOUT_W = $clog2(LSU_TIMEOUT + 1);

  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_load  = 2'd1,
    op_store = 2'd2
  } lsu_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  // register write-back source
  typedef enum logic [1:0] {
    wd_alu      = 2'd0,
    wd_mem      = 2'd1,
    wd_pc_plus4 = 2'd2,
    wd_src2     = 2'd3
  } wd_sel_e;

  typedef enum logic {
    csr_alu = 1'b0,
    csr_pc  = 1'b1
  } csr_sel_e;

  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_read_wait  = 2'd1,
    st_write_wait = 2'd2,
    st_done       = 2'd3
  } lsu_state_e;

  typedef struct packed {
    lsu_op_e     op;
    mem_size_e   size;
    logic        signed_load;
    // alu result that doubles as the memory address
    logic [31:0] addr;
    // src2
    logic [31:0] store_data;
    logic [31:0] pc;
    wd_sel_e     wd_sel;
    csr_sel_e    csr_sel;
    logic [4:0]  rd;
    logic [1:0]  csr_rd;
    logic        reg_we;
    logic        csr_we;
    logic        ecall;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] wd;
    logic [31:0] csr_wd;
    logic [4:0]  rd;
    logic [1:0]  csr_rd;
    logic        reg_we;
    logic        csr_we;
    logic        ecall;
    logic        fault;
  } lsu_wb_t;

endpackage

`default_nettype wire

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

  // master to slave with 32-bit data and byte strobes
  typedef struct packed {
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
  } axi_m2s_t;

  typedef struct packed {
    logic        arready;
    logic [31:0] rdata;
    axi_resp_e   rresp;
    logic        rvalid;
    logic        awready;
    logic        wready;
    axi_resp_e   bresp;
    logic        bvalid;
  } axi_s2m_t;

endpackage

`default_nettype wire

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl (
  input  wire                      clk,
  input  wire                      rst,
  input  wire lsu_pkg::lsu_req_t   req,
  input  wire                      req_valid,
  output logic                     req_ready,
  output logic                     wb_valid,
  input  wire                      wb_ready,
  output logic                     start_read,
  output logic                     start_write,
  input  wire                      rsp_done,
  input  wire                      rsp_err,
  input  wire                      expired,
  output logic                     wait_active,
  output lsu_pkg::lsu_req_t        held,
  output logic                     fault
);

  lsu_pkg::lsu_state_e state;
  logic                accept;

  assign req_ready = (state == lsu_pkg::st_idle);
  assign accept    = req_valid && req_ready;

  // bus phase starts on the accepting edge
  assign start_read  = accept && (req.op == lsu_pkg::op_load);
  assign start_write = accept && (req.op == lsu_pkg::op_store);

  assign wait_active = (state == lsu_pkg::st_read_wait) ||
                       (state == lsu_pkg::st_write_wait);
  assign wb_valid    = (state == lsu_pkg::st_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= lsu_pkg::st_idle;
      fault <= 1'b0;
    end else begin
      case (state)
        lsu_pkg::st_idle: begin
          if (accept) begin
            fault <= 1'b0;
            case (req.op)
              lsu_pkg::op_load:  state <= lsu_pkg::st_read_wait;
              lsu_pkg::op_store: state <= lsu_pkg::st_write_wait;
              default:           state <= lsu_pkg::st_done;
            endcase
          end
        end
        lsu_pkg::st_read_wait,
        lsu_pkg::st_write_wait: begin
          if (rsp_done) begin
            state <= lsu_pkg::st_done;
            fault <= rsp_err;
          end else if (expired) begin
            // slave never answered
            state <= lsu_pkg::st_done;
            fault <= 1'b1;
          end
        end
        lsu_pkg::st_done: begin
          if (wb_ready) begin
            state <= lsu_pkg::st_idle;
          end
        end
        default: begin
          state <= lsu_pkg::st_idle;
        end
      endcase
    end
  end

  // request stays put until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      held <= req;
    end
  end

  // no stale watchdog pulse when a new transfer starts
  a_start_no_expiry: assert property (@(posedge clk) disable iff (rst)
    (start_read || start_write) |-> !expired);

  // the bus port only answers while a transfer is outstanding
  a_no_rsp_in_idle: assert property (@(posedge clk) disable iff (rst)
    rsp_done |-> (state != lsu_pkg::st_idle));

endmodule

`default_nettype wire

// ==== lsu_timeout.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_timeout (
  input  wire  clk,
  input  wire  rst,
  input  wire  wait_active,
  input  wire  rsp_done,
  output logic expired
);

  localparam int W = lsu_pkg::LSU_TIMEOUT_W;

  logic [W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst || !wait_active || rsp_done) begin
      count   <= '0;
      expired <= 1'b0;
    end else begin
      // saturate at the limit so the pulse fires only once
      if (count != W'(lsu_pkg::LSU_TIMEOUT)) begin
        count <= count + 1'b1;
      end
      expired <= (count == W'(lsu_pkg::LSU_TIMEOUT - 1));
    end
  end

endmodule

`default_nettype wire

// ==== axi_lite_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_lite_port (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_read,
  input  wire                       start_write,
  // watchdog expiry ends the wait for a response
  input  wire                       abort,
  input  wire [31:0]                addr,
  input  wire [31:0]                store_data,
  input  wire lsu_pkg::mem_size_e   size,
  output axi_pkg::axi_m2s_t         axi_m,
  input  wire axi_pkg::axi_s2m_t    axi_s,
  output logic                      rsp_done,
  output logic [31:0]               rsp_data,
  output logic                      rsp_err
);

  logic        read_pend;
  logic        write_pend;
  logic        arvalid_q;
  logic        awvalid_q;
  logic        wvalid_q;
  logic [31:0] araddr_q;
  logic [31:0] awaddr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  logic [3:0]  strb;
  logic [31:0] lane_data;
  logic        r_hs;
  logic        b_hs;

  always_comb begin
    case (size)
      lsu_pkg::size_byte: strb = 4'b0001 << addr[1:0];
      lsu_pkg::size_half: strb = 4'b0011 << addr[1:0];
      default:            strb = 4'b1111;
    endcase
  end

  assign lane_data = store_data << {addr[1:0], 3'b000};

  always_comb begin
    axi_m.araddr  = araddr_q;
    axi_m.arvalid = arvalid_q;
    axi_m.rready  = read_pend && !arvalid_q;
    axi_m.awaddr  = awaddr_q;
    axi_m.awvalid = awvalid_q;
    axi_m.wdata   = wdata_q;
    axi_m.wstrb   = wstrb_q;
    axi_m.wvalid  = wvalid_q;
    // B only once both AW and W went through
    axi_m.bready  = write_pend && !awvalid_q && !wvalid_q;
  end

  assign r_hs     = axi_m.rready && axi_s.rvalid;
  assign b_hs     = axi_m.bready && axi_s.bvalid;
  assign rsp_done = r_hs || b_hs;
  assign rsp_err  = (r_hs && (axi_s.rresp != axi_pkg::resp_okay)) ||
                    (b_hs && (axi_s.bresp != axi_pkg::resp_okay));

  always_ff @(posedge clk) begin
    if (rst) begin
      read_pend  <= 1'b0;
      write_pend <= 1'b0;
      arvalid_q  <= 1'b0;
      awvalid_q  <= 1'b0;
      wvalid_q   <= 1'b0;
    end else begin
      if (start_read) begin
        arvalid_q <= 1'b1;
      end else if (arvalid_q && axi_s.arready) begin
        arvalid_q <= 1'b0;
      end
      if (start_write) begin
        awvalid_q <= 1'b1;
      end else if (awvalid_q && axi_s.awready) begin
        awvalid_q <= 1'b0;
      end
      if (start_write) begin
        wvalid_q <= 1'b1;
      end else if (wvalid_q && axi_s.wready) begin
        wvalid_q <= 1'b0;
      end
      // abort drops only the R or B wait and lets the valids finish
      if (start_read) begin
        read_pend <= 1'b1;
      end else if (r_hs || abort) begin
        read_pend <= 1'b0;
      end
      if (start_write) begin
        write_pend <= 1'b1;
      end else if (b_hs || abort) begin
        write_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_read) begin
      araddr_q <= {addr[31:2], 2'b00};
    end
    if (start_write) begin
      awaddr_q <= {addr[31:2], 2'b00};
      wdata_q  <= lane_data;
      wstrb_q  <= strb;
    end
    if (r_hs) begin
      rsp_data <= axi_s.rdata;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    axi_m.arvalid && !axi_s.arready |=> axi_m.arvalid && $stable(axi_m.araddr));

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    axi_m.awvalid && !axi_s.awready |=> axi_m.awvalid && $stable(axi_m.awaddr));

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    axi_m.wvalid && !axi_s.wready |=> axi_m.wvalid && $stable(axi_m.wdata));

endmodule

`default_nettype wire

// ==== load_extend.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_extend (
  input  wire lsu_pkg::lsu_req_t   held,
  input  wire [31:0]               rdata,
  input  wire                      fault,
  output lsu_pkg::lsu_wb_t         wb
);

  logic [31:0] lane;
  logic [31:0] load_val;

  // addressed byte moved down to bit 0
  assign lane = rdata >> {held.addr[1:0], 3'b000};

  always_comb begin
    case (held.size)
      lsu_pkg::size_byte: begin
        if (held.signed_load) begin
          load_val = {{24{lane[7]}}, lane[7:0]};
        end else begin
          load_val = {24'h0, lane[7:0]};
        end
      end
      lsu_pkg::size_half: begin
        if (held.signed_load) begin
          load_val = {{16{lane[15]}}, lane[15:0]};
        end else begin
          load_val = {16'h0, lane[15:0]};
        end
      end
      default: begin
        load_val = rdata;
      end
    endcase
  end

  always_comb begin
    case (held.wd_sel)
      lsu_pkg::wd_mem:      wb.wd = load_val;
      lsu_pkg::wd_pc_plus4: wb.wd = held.pc + 32'd4;
      lsu_pkg::wd_src2:     wb.wd = held.store_data;
      default:              wb.wd = held.addr;
    endcase
    if (held.csr_sel == lsu_pkg::csr_pc) begin
      wb.csr_wd = held.pc;
    end else begin
      wb.csr_wd = held.addr;
    end
    wb.rd     = held.rd;
    wb.csr_rd = held.csr_rd;
    // no write-back after a bus fault
    wb.reg_we = held.reg_we && !fault;
    wb.csr_we = held.csr_we && !fault;
    wb.ecall  = held.ecall;
    wb.fault  = fault;
  end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
  input  wire                      clk,
  input  wire                      rst,
  input  wire lsu_pkg::lsu_req_t   req,
  input  wire                      req_valid,
  output logic                     req_ready,
  output lsu_pkg::lsu_wb_t         wb,
  output logic                     wb_valid,
  input  wire                      wb_ready,
  output axi_pkg::axi_m2s_t        axi_m,
  input  wire axi_pkg::axi_s2m_t   axi_s
);

  lsu_pkg::lsu_req_t held;
  logic              start_read;
  logic              start_write;
  logic              rsp_done;
  logic              rsp_err;
  logic [31:0]       rsp_data;
  logic              expired;
  logic              wait_active;
  logic              fault;

  lsu_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .wb_valid    (wb_valid),
    .wb_ready    (wb_ready),
    .start_read  (start_read),
    .start_write (start_write),
    .rsp_done    (rsp_done),
    .rsp_err     (rsp_err),
    .expired     (expired),
    .wait_active (wait_active),
    .held        (held),
    .fault       (fault)
  );

  lsu_timeout u_timeout (
    .clk         (clk),
    .rst         (rst),
    .wait_active (wait_active),
    .rsp_done    (rsp_done),
    .expired     (expired)
  );

  // read data is held in the port until the next read
  axi_lite_port u_port (
    .clk         (clk),
    .rst         (rst),
    .start_read  (start_read),
    .start_write (start_write),
    .abort       (expired),
    .addr        (req.addr),
    .store_data  (req.store_data),
    .size        (req.size),
    .axi_m       (axi_m),
    .axi_s       (axi_s),
    .rsp_done    (rsp_done),
    .rsp_data    (rsp_data),
    .rsp_err     (rsp_err)
  );

  load_extend u_extend (
    .held  (held),
    .rdata (rsp_data),
    .fault (fault),
    .wb    (wb)
  );

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem #(
  parameter logic [31:0] ERR_ADDR = 32'h0000_0f00
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      stall_en,
  input  wire                      mute,
  input  wire axi_pkg::axi_m2s_t   axi_m,
  output axi_pkg::axi_s2m_t        axi_s
);

  logic [31:0] mem [0:63];
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;
  logic        r_pend;
  logic        aw_got;
  logic        w_got;
  logic [31:0] rnd;
  integer      seed = 32'ha37c;
  integer      b;

  always @(posedge clk) begin
    rnd = $random(seed);
    if (rst) begin
      axi_s  <= '0;
      r_pend <= 1'b0;
      aw_got <= 1'b0;
      w_got  <= 1'b0;
    end else begin
      // ready lines flicker while stalls are on
      axi_s.arready <= !stall_en || rnd[0];
      axi_s.awready <= !stall_en || rnd[1];
      axi_s.wready  <= !stall_en || rnd[2];

      // mute accepts requests and never answers
      if (axi_m.arvalid && axi_s.arready && !mute) begin
        r_pend  <= 1'b1;
        rd_addr <= axi_m.araddr;
      end
      if (axi_m.awvalid && axi_s.awready && !mute) begin
        aw_got  <= 1'b1;
        wr_addr <= axi_m.awaddr;
      end
      if (axi_m.wvalid && axi_s.wready && !mute) begin
        w_got   <= 1'b1;
        wr_data <= axi_m.wdata;
        wr_strb <= axi_m.wstrb;
      end

      if (axi_s.rvalid) begin
        if (axi_m.rready) begin
          axi_s.rvalid <= 1'b0;
        end
      end else if (r_pend && (!stall_en || rnd[3])) begin
        r_pend       <= 1'b0;
        axi_s.rvalid <= 1'b1;
        axi_s.rdata  <= mem[rd_addr[7:2]];
        if (rd_addr == ERR_ADDR) begin
          axi_s.rresp <= axi_pkg::resp_slverr;
        end else begin
          axi_s.rresp <= axi_pkg::resp_okay;
        end
      end

      // B needs both address and data
      if (axi_s.bvalid) begin
        if (axi_m.bready) begin
          axi_s.bvalid <= 1'b0;
        end
      end else if (aw_got && w_got && (!stall_en || rnd[4])) begin
        aw_got       <= 1'b0;
        w_got        <= 1'b0;
        axi_s.bvalid <= 1'b1;
        if (wr_addr == ERR_ADDR) begin
          axi_s.bresp <= axi_pkg::resp_slverr;
        end else begin
          axi_s.bresp <= axi_pkg::resp_okay;
          for (b = 0; b < 4; b = b + 1) begin
            if (wr_strb[b]) begin
              mem[wr_addr[7:2]][8*b +: 8] <= wr_data[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_top;

  localparam logic [31:0] ERR_ADDR   = 32'h0000_0f00;
  localparam int          WAIT_LIMIT = 200;

  logic               clk;
  logic               rst;
  lsu_pkg::lsu_req_t  req;
  logic               req_valid;
  logic               req_ready;
  lsu_pkg::lsu_wb_t   wb;
  logic               wb_valid;
  logic               wb_ready;
  axi_pkg::axi_m2s_t  axi_m;
  axi_pkg::axi_s2m_t  axi_s;
  logic               stall_en;
  logic               mute;
  logic               hold_off;
  int                 last_wait;
  axi_pkg::axi_resp_e last_resp;
  logic [31:0]        ref_mem [0:63];
  integer             seed = 32'ha37c;

  lsu_top DUT (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .wb        (wb),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .axi_m     (axi_m),
    .axi_s     (axi_s)
  );

  tb_axi_mem #(.ERR_ADDR(ERR_ADDR)) mem_model (
    .clk      (clk),
    .rst      (rst),
    .stall_en (stall_en),
    .mute     (mute),
    .axi_m    (axi_m),
    .axi_s    (axi_s)
  );

  always #10 clk = ~clk;

  // last response seen on R or B
  always @(posedge clk) begin
    if (axi_m.rready && axi_s.rvalid) begin
      last_resp <= axi_s.rresp;
    end
    if (axi_m.bready && axi_s.bvalid) begin
      last_resp <= axi_s.bresp;
    end
  end

  task automatic stop_with_fail();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    stop_with_fail();
  endtask

  task automatic timed_out(input string what);
    $display("gave up waiting for %s at t=%0t", what, $time);
    stop_with_fail();
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      mismatch(name, got, exp);
    end
  endtask

  task automatic resp_check(input string name, input axi_pkg::axi_resp_e got,
                            input axi_pkg::axi_resp_e exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      stop_with_fail();
    end
  endtask

  task automatic wb_compare(input lsu_pkg::lsu_wb_t got, input lsu_pkg::lsu_wb_t exp);
    compare_word("wb.wd", got.wd, exp.wd);
    compare_word("wb.csr_wd", got.csr_wd, exp.csr_wd);
    compare_word("wb.rd", 32'(got.rd), 32'(exp.rd));
    compare_word("wb.csr_rd", 32'(got.csr_rd), 32'(exp.csr_rd));
    compare_word("wb.reg_we", 32'(got.reg_we), 32'(exp.reg_we));
    compare_word("wb.csr_we", 32'(got.csr_we), 32'(exp.csr_we));
    compare_word("wb.ecall", 32'(got.ecall), 32'(exp.ecall));
    compare_word("wb.fault", 32'(got.fault), 32'(exp.fault));
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic issue(input lsu_pkg::lsu_req_t r);
    int n;
    n         = 0;
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      step();
      n++;
      if (n > WAIT_LIMIT) begin
        timed_out("req_ready");
      end
    end
    step();
    req_valid = 1'b0;
  endtask

  task automatic collect(output lsu_pkg::lsu_wb_t got);
    lsu_pkg::lsu_wb_t snap;
    logic [31:0]      bits;
    int               n;
    int               k;
    n = 0;
    while (!wb_valid) begin
      step();
      n++;
      if (n > WAIT_LIMIT) begin
        timed_out("wb_valid");
      end
    end
    last_wait = n;
    // stall the result for a random span
    if (hold_off) begin
      bits = $random(seed);
      snap = wb;
      for (k = 0; k <= int'(bits[2:0]); k++) begin
        step();
        wb_compare(wb, snap);
        compare_word("wb_valid", 32'(wb_valid), 32'd1);
        compare_word("req_ready", 32'(req_ready), 32'd0);
        compare_word("axi valids/readies",
                     32'({axi_m.arvalid, axi_m.awvalid, axi_m.wvalid,
                          axi_m.rready, axi_m.bready}), 32'd0);
      end
    end
    got      = wb;
    wb_ready = 1'b1;
    step();
    wb_ready = 1'b0;
  endtask

  task automatic shadow_store(input lsu_pkg::lsu_req_t r);
    int off;
    int nbytes;
    int k;
    off = int'(r.addr[1:0]);
    case (r.size)
      lsu_pkg::size_byte: nbytes = 1;
      lsu_pkg::size_half: nbytes = 2;
      default:            nbytes = 4;
    endcase
    for (k = 0; k < nbytes; k++) begin
      ref_mem[r.addr[7:2]][8*(off+k) +: 8] = r.store_data[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] expected_load(input lsu_pkg::lsu_req_t r);
    logic [31:0] word;
    logic [31:0] val;
    logic [7:0]  lo;
    logic [7:0]  hi;
    int          off;
    word = ref_mem[r.addr[7:2]];
    off  = int'(r.addr[1:0]);
    lo   = word[8*off +: 8];
    // upper byte of a half sits at the odd offset
    hi   = word[8*(off | 1) +: 8];
    case (r.size)
      lsu_pkg::size_byte: val = r.signed_load ? {{24{lo[7]}}, lo} : {24'h0, lo};
      lsu_pkg::size_half: val = r.signed_load ? {{16{hi[7]}}, hi, lo} : {16'h0, hi, lo};
      default:            val = word;
    endcase
    return val;
  endfunction

  function automatic lsu_pkg::lsu_wb_t predict_wb(input lsu_pkg::lsu_req_t r,
                                                  input logic [31:0] load_val,
                                                  input logic flt);
    lsu_pkg::lsu_wb_t e;
    case (r.wd_sel)
      lsu_pkg::wd_mem:      e.wd = load_val;
      lsu_pkg::wd_pc_plus4: e.wd = r.pc + 32'd4;
      lsu_pkg::wd_src2:     e.wd = r.store_data;
      default:              e.wd = r.addr;
    endcase
    e.csr_wd = (r.csr_sel == lsu_pkg::csr_pc) ? r.pc : r.addr;
    e.rd     = r.rd;
    e.csr_rd = r.csr_rd;
    e.reg_we = r.reg_we && !flt;
    e.csr_we = r.csr_we && !flt;
    e.ecall  = r.ecall;
    e.fault  = flt;
    return e;
  endfunction

  function automatic lsu_pkg::lsu_req_t rand_req(input lsu_pkg::lsu_op_e op,
                                                 input lsu_pkg::mem_size_e size,
                                                 input logic [1:0] off);
    lsu_pkg::lsu_req_t r;
    logic [31:0]       bits;
    bits           = $random(seed);
    r.op           = op;
    r.size         = size;
    r.signed_load  = bits[0];
    r.addr         = {24'h0, bits[13:8], off};
    r.store_data   = $random(seed);
    r.pc           = $random(seed);
    r.rd           = bits[20:16];
    r.csr_rd       = bits[22:21];
    r.reg_we       = bits[23];
    r.csr_we       = bits[24];
    r.ecall        = bits[25];
    r.csr_sel      = bits[26] ? lsu_pkg::csr_pc : lsu_pkg::csr_alu;
    case (bits[28:27])
      2'd0:    r.wd_sel = lsu_pkg::wd_pc_plus4;
      2'd1:    r.wd_sel = lsu_pkg::wd_src2;
      default: r.wd_sel = lsu_pkg::wd_alu;
    endcase
    if (op == lsu_pkg::op_load) begin
      r.wd_sel = lsu_pkg::wd_mem;
    end
    return r;
  endfunction

  task automatic run_op(input lsu_pkg::lsu_req_t r, input logic flt);
    lsu_pkg::lsu_wb_t got;
    issue(r);
    // bus request or result shows up one cycle after acceptance
    case (r.op)
      lsu_pkg::op_load:  compare_word("arvalid", 32'(axi_m.arvalid), 32'd1);
      lsu_pkg::op_store: compare_word("awvalid/wvalid", 32'(axi_m.awvalid && axi_m.wvalid), 32'd1);
      default:           compare_word("wb_valid", 32'(wb_valid), 32'd1);
    endcase
    collect(got);
    if (r.op == lsu_pkg::op_store && !flt) begin
      shadow_store(r);
    end
    wb_compare(got, predict_wb(r, expected_load(r), flt));
  endtask

  task automatic random_access();
    logic [31:0]        bits;
    lsu_pkg::mem_size_e size;
    lsu_pkg::lsu_op_e   op;
    logic [1:0]         off;
    bits = $random(seed);
    case (bits[1:0])
      2'd0: begin
        size = lsu_pkg::size_byte;
        off  = bits[3:2];
      end
      2'd1: begin
        size = lsu_pkg::size_half;
        off  = {bits[2], 1'b0};
      end
      default: begin
        size = lsu_pkg::size_word;
        off  = 2'd0;
      end
    endcase
    case (bits[5:4])
      2'd0:    op = lsu_pkg::op_none;
      2'd1:    op = lsu_pkg::op_store;
      default: op = lsu_pkg::op_load;
    endcase
    run_op(rand_req(op, size, off), 1'b0);
  endtask

  task automatic preload_memory();
    lsu_pkg::lsu_req_t r;
    int                i;
    for (i = 0; i < 64; i++) begin
      r            = rand_req(lsu_pkg::op_store, lsu_pkg::size_word, 2'd0);
      r.addr       = 32'(i * 4);
      r.store_data = (r.addr * 32'h0101_0101) ^ 32'h5a3c_96e1;
      run_op(r, 1'b0);
    end
  endtask

  task automatic non_mem_ops();
    lsu_pkg::lsu_req_t r;
    int                i;
    for (i = 0; i < 12; i++) begin
      r = rand_req(lsu_pkg::op_none, lsu_pkg::size_word, 2'd0);
      case (i % 3)
        0:       r.wd_sel = lsu_pkg::wd_alu;
        1:       r.wd_sel = lsu_pkg::wd_pc_plus4;
        default: r.wd_sel = lsu_pkg::wd_src2;
      endcase
      r.csr_sel = ((i / 3) % 2 == 1) ? lsu_pkg::csr_pc : lsu_pkg::csr_alu;
      run_op(r, 1'b0);
    end
  endtask

  task automatic store_offsets();
    lsu_pkg::lsu_req_t r;
    lsu_pkg::lsu_req_t chk;
    int                s;
    int                off;
    for (s = 0; s < 3; s++) begin
      for (off = 0; off < 4; off += (1 << s)) begin
        r = rand_req(lsu_pkg::op_store, lsu_pkg::mem_size_e'(2'(s)), 2'(off));
        run_op(r, 1'b0);
        chk      = rand_req(lsu_pkg::op_load, lsu_pkg::size_word, 2'd0);
        chk.addr = {r.addr[31:2], 2'b00};
        run_op(chk, 1'b0);
      end
    end
  endtask

  task automatic load_extension();
    lsu_pkg::lsu_req_t r;
    int                s;
    int                off;
    int                g;
    for (s = 0; s < 3; s++) begin
      for (off = 0; off < 4; off += (1 << s)) begin
        for (g = 0; g < 2; g++) begin
          r             = rand_req(lsu_pkg::op_load, lsu_pkg::mem_size_e'(2'(s)), 2'(off));
          r.signed_load = (g == 1);
          run_op(r, 1'b0);
        end
      end
    end
  endtask

  task automatic bus_faults();
    lsu_pkg::lsu_req_t r;
    r        = rand_req(lsu_pkg::op_load, lsu_pkg::size_word, 2'd0);
    r.addr   = ERR_ADDR;
    r.wd_sel = lsu_pkg::wd_alu;
    r.reg_we = 1'b1;
    r.csr_we = 1'b1;
    run_op(r, 1'b1);
    resp_check("rresp", last_resp, axi_pkg::resp_slverr);
    run_op(rand_req(lsu_pkg::op_load, lsu_pkg::size_word, 2'd0), 1'b0);
    r.op = lsu_pkg::op_store;
    run_op(r, 1'b1);
    resp_check("bresp", last_resp, axi_pkg::resp_slverr);
    run_op(rand_req(lsu_pkg::op_load, lsu_pkg::size_word, 2'd0), 1'b0);
    // only the watchdog ends these on a silent slave
    mute   = 1'b1;
    r.addr = 32'h0000_0040;
    r.op   = lsu_pkg::op_load;
    run_op(r, 1'b1);
    if (last_wait < lsu_pkg::LSU_TIMEOUT) begin
      $display("muted load ended after %0d cycles, before the watchdog limit", last_wait);
      stop_with_fail();
    end
    r.op = lsu_pkg::op_store;
    run_op(r, 1'b1);
    mute = 1'b0;
    run_op(rand_req(lsu_pkg::op_load, lsu_pkg::size_word, 2'd0), 1'b0);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    wb_ready  = 1'b0;
    stall_en  = 1'b0;
    mute      = 1'b0;
    hold_off  = 1'b0;
    last_wait = 0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    compare_word("req_ready", 32'(req_ready), 32'd1);
    compare_word("wb_valid", 32'(wb_valid), 32'd0);
    compare_word("axi valids/readies", 32'({axi_m.arvalid, axi_m.awvalid, axi_m.wvalid,
                                           axi_m.rready, axi_m.bready}), 32'd0);
    preload_memory();
    non_mem_ops();
    store_offsets();
    load_extension();
    hold_off = 1'b1;
    repeat (30) random_access();
    hold_off = 1'b0;
    stall_en = 1'b1;
    repeat (40) random_access();
    stall_en = 1'b0;
    bus_faults();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsu_top.f ====
lsu_pkg.sv
axi_pkg.sv
lsu_ctrl.sv
lsu_timeout.sv
axi_lite_port.sv
load_extend.sv
lsu_top.sv
tb_axi_mem.sv
tb_lsu_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lsu_top -f lsu_top.f

output=$(./obj_dir/Vtb_lsu_top 2>&1) || true
echo "$output"
echo "$output" | grep -q "TEST PASS"
